// ==== Bender.yml ====
package:
  name: credit_link

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/credit_link_pkg.sv
      - logic/credit_counter.sv
      - logic/lane_dispatch.sv
      - logic/credit_lane.sv
      - logic/lane_arbiter.sv
      - logic/credit_link_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/credit_link_tb.sv

// ==== flist.f ====
+incdir+logic
logic/credit_link_pkg.sv
logic/credit_counter.sv
logic/lane_dispatch.sv
logic/credit_lane.sv
logic/lane_arbiter.sv
logic/credit_link_top.sv
verif/credit_link_tb.sv

// ==== logic/credit_counter.sv ====
// Sender-side credit pool, one credit per flit
// Caller keeps the count within 0..CL_BUF_DEPTH
// Increment and decrement may land in the same cycle
// available counts the increment but never the decrement

`default_nettype none

`include "credit_link_config.svh"

module credit_counter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     incr_valid,
  input  logic                     decr_valid,
  input  credit_link_pkg::credit_t incr,
  input  credit_link_pkg::credit_t decr,
  input  credit_link_pkg::credit_t initial_value,
  input  credit_link_pkg::credit_t withhold,
  output credit_link_pkg::credit_t value,
  output credit_link_pkg::credit_t available
);

  import credit_link_pkg::*;

  localparam int cw = $bits(credit_t);

  // One extra bit so overflow and wrap are visible
  logic [cw:0] ext_plus;
  logic [cw:0] ext_next;

  credit_t value_plus_incr;
  credit_t value_next;

  // ------------------------------------------------------------
  // Counter
  // ------------------------------------------------------------

  assign ext_plus = {1'b0, value} + (incr_valid ? {1'b0, incr} : '0);
  assign ext_next = ext_plus - (decr_valid ? {1'b0, decr} : '0);

  assign value_plus_incr = ext_plus[cw-1:0];
  assign value_next      = ext_next[cw-1:0];

  // Reload on reset, hold when idle
  always_ff @(posedge clk) begin
    if (rst) begin
      value <= initial_value;
    end else if (incr_valid || decr_valid) begin
      value <= value_next;
    end
  end

  // Returned credit is usable in the cycle it arrives
  // Withhold may exceed the pool, floor at zero
  assign available = (value_plus_incr > withhold) ? credit_t'(value_plus_incr - withhold) : '0;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Link carries single credits only
  incr_in_range_a: assert property (@(posedge clk) disable iff (rst)
    incr_valid |-> incr <= credit_t'(1));
  decr_in_range_a: assert property (@(posedge clk) disable iff (rst)
    decr_valid |-> decr <= credit_t'(1));

  // Pool never grows past the buffer it guards
  no_overflow_a: assert property (@(posedge clk) disable iff (rst)
    ext_next <= (cw + 1)'(`CL_BUF_DEPTH));

  // Spending more than held
  no_underflow_a: assert property (@(posedge clk) disable iff (rst)
    decr_valid |-> ext_plus >= {1'b0, decr});

  // Without a return in flight, withhold only ever shrinks the count
  avail_le_value_a: assert property (@(posedge clk) disable iff (rst)
    !incr_valid |-> available <= value);

endmodule

`default_nettype wire

// ==== logic/credit_lane.sv ====
// One virtual lane: credit gate, link pipeline, receive buffer, credit return
// Credits bound buffer occupancy, so the buffer never sees back-pressure
// credit_init is sampled only while rst is high
// Sending is held off through the first cycle after reset release

`default_nettype none

`include "credit_link_config.svh"

module credit_lane (
  input  logic                     clk,
  input  logic                     rst,
  input  credit_link_pkg::credit_t credit_init,
  input  credit_link_pkg::credit_t withhold,
  input  logic                     lane_valid,
  output logic                     lane_ready,
  input  credit_link_pkg::flit_t   lane_flit,
  output logic                     head_valid,
  output credit_link_pkg::flit_t   head_flit,
  input  logic                     pop
);

  import credit_link_pkg::*;

  localparam int link_delay = `CL_LINK_DELAY;
  localparam int ret_delay  = `CL_RET_DELAY;
  localparam int depth      = `CL_BUF_DEPTH;
  localparam int ptr_w      = (depth > 1) ? $clog2(depth) : 1;

  credit_t credit_value;
  credit_t credit_avail;
  logic    link_up;
  logic    send;

  // Link and return pipelines
  logic  [link_delay-1:0] link_valid;
  flit_t                  link_flit [link_delay];
  logic  [ret_delay-1:0]  ret_valid;

  // Receive buffer
  flit_t             mem [depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  credit_t           count;
  logic              wr_en;
  int                credits_total;

  // ------------------------------------------------------------
  // Sender credit gate
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      link_up <= 1'b0;
    end else begin
      link_up <= 1'b1;
    end
  end

  assign lane_ready = link_up && (credit_avail != '0);
  assign send       = lane_valid && lane_ready;

  credit_counter u_counter (
    .clk           (clk),
    .rst           (rst),
    .incr_valid    (ret_valid[ret_delay-1]),
    .decr_valid    (send),
    .incr          (credit_t'(1)),
    .decr          (credit_t'(1)),
    .initial_value (credit_init),
    .withhold      (withhold),
    .value         (credit_value),
    .available     (credit_avail)
  );

  // ------------------------------------------------------------
  // Link pipeline, several flits may be in flight
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      link_valid <= '0;
    end else begin
      link_valid[0] <= send;
      for (int i = 1; i < link_delay; i++) begin
        link_valid[i] <= link_valid[i-1];
      end
    end
  end

  // Payload moves with its valid bit, no reset needed
  always_ff @(posedge clk) begin
    link_flit[0] <= lane_flit;
    for (int i = 1; i < link_delay; i++) begin
      link_flit[i] <= link_flit[i-1];
    end
  end

  assign wr_en = link_valid[link_delay-1];

  // ------------------------------------------------------------
  // Receive buffer
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= link_flit[link_delay-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : ptr_w'(wr_ptr + 1'b1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : ptr_w'(rd_ptr + 1'b1);
      end
      count <= count + credit_t'(wr_en) - credit_t'(pop);
    end
  end

  assign head_valid = (count != '0);
  assign head_flit  = mem[rd_ptr];

  // Each pop sends one credit back after ret_delay cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid <= '0;
    end else begin
      ret_valid[0] <= pop;
      for (int i = 1; i < ret_delay; i++) begin
        ret_valid[i] <= ret_valid[i-1];
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Credits held plus every flit or credit in transit
  always_comb begin
    credits_total = int'(credit_value) + $countones(link_valid) + int'(count)
                  + $countones(ret_valid);
  end

  no_write_full_a: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> count < credit_t'(depth));
  no_pop_empty_a: assert property (@(posedge clk) disable iff (rst)
    pop |-> head_valid);
  credits_bounded_a: assert property (@(posedge clk) disable iff (rst)
    credits_total <= depth);

endmodule

`default_nettype wire

// ==== logic/credit_link_config.svh ====
// Build-time sizing for the credit link
// CL_NUM_LANES must be a power of two and at least 2
// CL_BUF_DEPTH is also the largest legal credit count per lane
// Both delays must be at least 1

`ifndef CREDIT_LINK_CONFIG_SVH
`define CREDIT_LINK_CONFIG_SVH

// Number of virtual lanes
`define CL_NUM_LANES 4

// Flit payload width in bits
`define CL_DATA_W 16

// Receive buffer entries per lane
`define CL_BUF_DEPTH 4

// Register stages from sender to receive buffer
`define CL_LINK_DELAY 2

// Register stages on the credit return path
`define CL_RET_DELAY 2

`endif

// ==== logic/credit_link_pkg.sv ====
// Shared types for the credit link
// Widths follow the macros in the config header

`default_nettype none

`include "credit_link_config.svh"

package credit_link_pkg;

  // Lane index, log2 of the lane count
  typedef logic [$clog2(`CL_NUM_LANES)-1:0] lane_t;

  // Credit count, covers 0 up to the buffer depth inclusive
  typedef logic [$clog2(`CL_BUF_DEPTH + 1)-1:0] credit_t;

  // One flit on the link
  // Lane field sits above the payload
  typedef struct packed {
    lane_t                 lane;
    logic [`CL_DATA_W-1:0] data;
  } flit_t;

endpackage

`default_nettype wire

// ==== logic/credit_link_top.sv ====
// Credit-flow-controlled link with CL_NUM_LANES virtual lanes
// credit_init applies at reset, withhold is live per lane
// Single clock domain

`default_nettype none

`include "credit_link_config.svh"

module credit_link_top (
  input  logic                     clk,
  input  logic                     rst,
  input  credit_link_pkg::credit_t credit_init,
  input  credit_link_pkg::credit_t withhold [`CL_NUM_LANES],
  input  logic                     in_valid,
  output logic                     in_ready,
  input  credit_link_pkg::flit_t   in_flit,
  output logic                     out_valid,
  input  logic                     out_ready,
  output credit_link_pkg::flit_t   out_flit
);

  import credit_link_pkg::*;

  logic [`CL_NUM_LANES-1:0] lane_valid;
  logic [`CL_NUM_LANES-1:0] lane_ready;
  logic [`CL_NUM_LANES-1:0] head_valid;
  logic [`CL_NUM_LANES-1:0] pop;
  flit_t                    lane_flit;
  flit_t                    head_flit [`CL_NUM_LANES];

  lane_dispatch u_dispatch (
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_flit    (in_flit),
    .lane_valid (lane_valid),
    .lane_flit  (lane_flit),
    .lane_ready (lane_ready)
  );

  // One lane per virtual channel
  for (genvar g = 0; g < `CL_NUM_LANES; g++) begin : g_lane
    credit_lane u_lane (
      .clk         (clk),
      .rst         (rst),
      .credit_init (credit_init),
      .withhold    (withhold[g]),
      .lane_valid  (lane_valid[g]),
      .lane_ready  (lane_ready[g]),
      .lane_flit   (lane_flit),
      .head_valid  (head_valid[g]),
      .head_flit   (head_flit[g]),
      .pop         (pop[g])
    );
  end

  lane_arbiter u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .head_flit  (head_flit),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_flit   (out_flit)
  );

endmodule

`default_nettype wire

// ==== logic/lane_arbiter.sv ====
// Round-robin merge of lane buffer heads onto one egress stream
// Search starts at the lane after the last winner
// A stalled grant stays put until out_ready comes back

`default_nettype none

`include "credit_link_config.svh"

module lane_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [`CL_NUM_LANES-1:0]       head_valid,
  input  credit_link_pkg::flit_t         head_flit [`CL_NUM_LANES],
  output logic [`CL_NUM_LANES-1:0]       pop,
  output logic                           out_valid,
  input  logic                           out_ready,
  output credit_link_pkg::flit_t         out_flit
);

  import credit_link_pkg::*;

  localparam int n = `CL_NUM_LANES;

  lane_t last_win;
  lane_t pick;
  lane_t held_lane;
  lane_t sel;
  logic  found;
  logic  held;

  // Rotating search, wraps by natural overflow of lane_t
  always_comb begin
    lane_t idx;
    pick  = last_win;
    found = 1'b0;
    for (int k = 1; k <= n; k++) begin
      idx = last_win + lane_t'(k);
      if (!found && head_valid[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  // Locked lane keeps its head valid, nobody else pops it
  assign sel       = held ? held_lane : pick;
  assign out_valid = held || found;
  assign out_flit  = head_flit[sel];

  always_comb begin
    pop      = '0;
    pop[sel] = out_valid && out_ready;
  end

  // ------------------------------------------------------------
  // Grant state
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      last_win <= '1;
      held     <= 1'b0;
    end else begin
      held <= out_valid && !out_ready;
      if (out_valid && out_ready) begin
        last_win <= sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    held_lane <= sel;
  end

  // Stall keeps the offer unchanged into the next cycle
  stall_stable_a: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

`default_nettype wire

// ==== logic/lane_dispatch.sv ====
// Steers the ingress flit to the lane named in its lane field
// Purely combinational, in_ready follows the target lane only
// A flit bound for a blocked lane stalls every other lane behind it

`default_nettype none

`include "credit_link_config.svh"

module lane_dispatch (
  input  logic                           in_valid,
  output logic                           in_ready,
  input  credit_link_pkg::flit_t         in_flit,
  output logic [`CL_NUM_LANES-1:0]       lane_valid,
  output credit_link_pkg::flit_t         lane_flit,
  input  logic [`CL_NUM_LANES-1:0]       lane_ready
);

  import credit_link_pkg::*;

  lane_t sel;

  assign sel = in_flit.lane;

  // One-hot decode of the target lane
  always_comb begin
    lane_valid      = '0;
    lane_valid[sel] = in_valid;
  end

  // Every lane sees the same flit, only one takes it
  assign lane_flit = in_flit;

  // Handshake back from the chosen lane
  assign in_ready = lane_ready[sel];

  // Never offer a flit to two lanes
  always_comb begin
    one_lane_a: assert final ($onehot0(lane_valid));
  end

endmodule

`default_nettype wire

// ==== verif/credit_link_tb.sv ====
// Self-checking testbench for credit_link_top
// Stimulus comes from a fixed-seed LFSR, so every run repeats exactly
// credit_init takes effect only through a reset, withhold acts at once
// The first failed check ends the run

`default_nettype none

`include "credit_link_config.svh"

module credit_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import credit_link_pkg::*;

  localparam int n_lanes     = `CL_NUM_LANES;
  localparam int data_w      = `CL_DATA_W;
  localparam int clk_period  = 100;
  localparam int p1_flits    = 200;
  localparam int p2_flits    = 120;
  localparam int p3_flits    = 150;
  // One more flit comes from the withhold phase
  localparam int total_flits = p1_flits + p2_flits + p3_flits + 1;
  // Generous per-flit bound, covers the heavy stall phase
  localparam int cycles_per_flit = 40;
  localparam int watchdog_cycles = total_flits * cycles_per_flit + 400;
  localparam int wait_limit  = 200;
  localparam int hold_cycles = 16;
  localparam int wh_lane     = 2;
  localparam credit_t low_init = credit_t'(2);

  logic    clk;
  logic    rst;
  credit_t credit_init;
  credit_t withhold [n_lanes];
  logic    in_valid;
  logic    in_ready;
  flit_t   in_flit;
  logic    out_valid;
  logic    out_ready;
  flit_t   out_flit;

  // Scoreboard, one queue of accepted flits per lane
  flit_t       sb_q [n_lanes][$];
  int          outstanding [n_lanes];
  credit_t     cur_init;
  int          total_in;
  int          total_out;
  logic        in_fire;
  logic [31:0] lfsr;

  credit_link_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .credit_init (credit_init),
    .withhold    (withhold),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_flit     (in_flit),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_flit    (out_flit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Stopping at the first error");
  endtask

  // Galois LFSR, one step per bit
  function automatic logic lfsr_step();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  function automatic bit queues_empty();
    bit empty;
    empty = 1'b1;
    for (int k = 0; k < n_lanes; k++) begin
      if (sb_q[k].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  // ------------------------------------------------------------
  // Scoreboard and checks, sampled on the rising edge
  // ------------------------------------------------------------

  always @(posedge clk) begin : scoreboard
    lane_t ol;
    lane_t il;
    in_fire = in_valid && in_ready;
    if (rst) begin
      // Credit pool reloads from credit_init while reset is high
      cur_init = credit_init;
      for (int k = 0; k < n_lanes; k++) begin
        outstanding[k] = 0;
        sb_q[k].delete();
      end
    end else begin
      if (out_valid && out_ready) begin
        ol = out_flit.lane;
        if (sb_q[ol].size() == 0) begin
          abort_run($sformatf("Egress flit on lane %0d with nothing sent on that lane", ol));
        end else begin
          out_match_a: assert (out_flit == sb_q[ol][0])
            else abort_run($sformatf("FAILED %0t: lane %0d expected %h, got %h",
                                     $time, ol, sb_q[ol][0], out_flit));
          void'(sb_q[ol].pop_front());
          outstanding[ol]--;
          total_out++;
        end
      end
      if (in_fire) begin
        il = in_flit.lane;
        // No transfer while the whole pool is withheld
        withhold_block_a: assert (withhold[il] < cur_init)
          else abort_run($sformatf("FAILED %0t: lane %0d accepted a flit while withheld",
                                   $time, il));
        sb_q[il].push_back(in_flit);
        outstanding[il]++;
        total_in++;
      end
      for (int k = 0; k < n_lanes; k++) begin
        credit_bound_a: assert (outstanding[k] <= int'(cur_init))
          else abort_run($sformatf("FAILED %0t: lane %0d has %0d flits out, limit %0d",
                                   $time, k, outstanding[k], cur_init));
      end
    end
  end

  stall_hold_a: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_flit))
    else abort_run($sformatf("FAILED %0t: egress offer changed during a stall", $time));

  reset_idle_a: assert property (@(posedge clk)
    $fell(rst) |-> !out_valid && !in_ready)
    else abort_run($sformatf("FAILED %0t: handshake active right after reset", $time));

  // ------------------------------------------------------------
  // Stimulus, driven on the falling edge
  // ------------------------------------------------------------

  // out_ready is high in ready_quarters out of four cycles
  task automatic run_traffic(input int count, input int ready_quarters);
    int issued;
    issued = 0;
    while (issued < count || in_valid) begin
      @(negedge clk);
      out_ready = (rand_bits(2) < ready_quarters);
      if (in_valid && in_fire) begin
        in_valid = 1'b0;
      end
      if (!in_valid && issued < count && rand_bits(2) != 0) begin
        in_flit.lane = lane_t'(rand_bits($bits(lane_t)));
        in_flit.data = data_w'(rand_bits(data_w));
        in_valid     = 1'b1;
        issued++;
      end
    end
  endtask

  // Empty every lane, then let returned credits land
  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while (!queues_empty()) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) begin
        abort_run("Timeout: flits stuck in the link while draining");
      end
    end
    repeat (`CL_RET_DELAY + 2) @(negedge clk);
  endtask

  task automatic apply_reset(input credit_t init);
    @(negedge clk);
    credit_init = init;
    rst         = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  // Offer one flit to a fully withheld lane, then release it
  task automatic hold_and_release();
    int waited;
    waited = 0;
    @(negedge clk);
    withhold[wh_lane] = cur_init;
    out_ready         = 1'b1;
    in_flit.lane      = lane_t'(wh_lane);
    in_flit.data      = data_w'(rand_bits(data_w));
    in_valid          = 1'b1;
    repeat (hold_cycles) @(negedge clk);
    withhold[wh_lane] = '0;
    while (!in_fire) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) begin
        abort_run("Timeout: held flit was never accepted after withhold release");
      end
    end
    in_valid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    lfsr        = 32'he2cb18e0;
    rst         = 1'b1;
    credit_init = credit_t'(`CL_BUF_DEPTH);
    for (int k = 0; k < n_lanes; k++) begin
      withhold[k] = '0;
    end
    in_valid  = 1'b0;
    in_flit   = '0;
    out_ready = 1'b0;
    in_fire   = 1'b0;
    cur_init  = credit_init;
    total_in  = 0;
    total_out = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Full credits, light stalls
    run_traffic(p1_flits, 3);
    drain();
    // Heavy out_ready stalls
    run_traffic(p2_flits, 1);
    drain();
    // Smaller credit pool after a fresh reset
    apply_reset(low_init);
    run_traffic(p3_flits, 3);
    drain();
    // Withhold one lane completely, then let it go
    hold_and_release();
    drain();

    if (queues_empty() && total_in == total_out && total_in == total_flits) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run($sformatf("FAILED %0t: %0d flits in, %0d flits out, %0d expected",
                          $time, total_in, total_out, total_flits));
    end
  end

  // Ends a hung run
  initial begin
    #(watchdog_cycles * clk_period);
    abort_run("Timeout: the run did not finish within the watchdog limit");
  end

endmodule

`default_nettype wire
